// ==== common/mem_stage_defines.svh ====
`ifndef MEM_STAGE_DEFINES_SVH
`define MEM_STAGE_DEFINES_SVH

// Datapath widths
`define MEM_DATA_W      32  // Data word
`define MEM_ADDR_W      32  // Byte address
`define MEM_REG_W       5   // Register file index

// Bank array geometry
`define MEM_NUM_BANKS   4   // Must stay a power of two
`define MEM_BANK_DEPTH  64  // Words per bank

// Derived address field widths
`define MEM_BANK_SEL_W  $clog2(`MEM_NUM_BANKS)
`define MEM_ROW_W       $clog2(`MEM_BANK_DEPTH)

// Byte offset inside a word, dropped from every address
`define MEM_BYTE_OFS_W  2

`endif

// ==== common/mem_pkg.sv ====
`include "mem_stage_defines.svh"

package mem_pkg;

    // Memory operation carried by each execute record
    typedef enum logic [1:0]
    {
        op_none  = 2'd0,
        op_load  = 2'd1,
        op_store = 2'd2
    } mem_op_t;

    // Execute to memory pipeline record
    typedef struct packed
    {
        logic [`MEM_ADDR_W-1:0] alu_result;    // Also the access address
        logic [`MEM_DATA_W-1:0] store_data;
        mem_op_t                op;
        logic                   mem_to_reg;    // Passed through to write-back
        logic                   reg_write;
        logic [`MEM_REG_W-1:0]  reg_dest;
        logic                   pc_src;
        logic [`MEM_ADDR_W-1:0] branch_target;
    } ex_mem_t;

    // Memory to write-back pipeline record
    typedef struct packed
    {
        logic [`MEM_DATA_W-1:0] load_data;     // Zero unless a load
        logic [`MEM_ADDR_W-1:0] alu_result;
        logic                   mem_to_reg;
        logic                   reg_write;
        logic [`MEM_REG_W-1:0]  reg_dest;
        logic                   pc_src;
        logic [`MEM_ADDR_W-1:0] branch_target;
    } mem_wb_t;

    // Word request toward the bank array
    typedef struct packed
    {
        logic [`MEM_ADDR_W-1:0] addr;          // Byte address
        logic [`MEM_DATA_W-1:0] wdata;
        logic                   write;         // High for a store
    } bank_req_t;

    // Word response from a bank
    typedef struct packed
    {
        logic [`MEM_DATA_W-1:0] rdata;
    } bank_rsp_t;

endpackage

// ==== mem_stage/mem_stage.sv ====
`timescale 1ns/1ps
`include "mem_stage_defines.svh"

module mem_stage
    import mem_pkg::*;
(
    input  logic      clk,
    input  logic      rst,

    // From execute
    input  logic      ex_valid,
    input  ex_mem_t   ex_data,

    // Response from the bank array
    input  logic      done,
    input  bank_rsp_t rsp,

    // Back-pressure toward execute
    output logic      stall,

    // Request to the bank array
    output logic      req_valid,
    output bank_req_t req,

    // To write-back
    output logic      wb_valid,
    output mem_wb_t   wb_data
);

    ex_mem_t held;       // Record occupying the memory path
    logic    accept;     // Upstream record taken on this edge
    logic    is_mem_op;  // Incoming record needs a bank access
    logic    finish;     // Outstanding access completes on this edge

    // Build a write-back record from a pipeline record and a load word
    function automatic mem_wb_t make_wb(input ex_mem_t r, input logic [`MEM_DATA_W-1:0] ld);
        mem_wb_t w;
        w.load_data     = ld;
        w.alu_result    = r.alu_result;
        w.mem_to_reg    = r.mem_to_reg;
        w.reg_write     = r.reg_write;
        w.reg_dest      = r.reg_dest;
        w.pc_src        = r.pc_src;
        w.branch_target = r.branch_target;
        return w;
    endfunction

    assign accept    = ex_valid && !stall;
    assign is_mem_op = (ex_data.op != op_none);
    assign finish    = stall && done;  // done only arrives while stalled

    // Request fields come from the registered record
    always_comb
    begin
        req.addr  = held.alu_result;
        req.wdata = held.store_data;
        req.write = (held.op == op_store);  // Registered op decides the write
    end

    // Control state
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            stall     <= 1'b0;
            req_valid <= 1'b0;
            wb_valid  <= 1'b0;
        end
        else
        begin
            // One-cycle request strobe on acceptance of a load or store
            req_valid <= accept && is_mem_op;

            if (accept && is_mem_op)
            begin
                stall <= 1'b1;  // Hold upstream until the bank answers
            end
            else if (finish)
            begin
                stall <= 1'b0;
            end

            // Pass-through records leave at once, memory records on done
            wb_valid <= (accept && !is_mem_op) || finish;
        end
    end

    // Payload registers
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            held <= ex_data;  // Kept stable while stalled
        end

        if (accept && !is_mem_op)
        begin
            wb_data <= make_wb(ex_data, '0);
        end
        else if (finish)
        begin
            // Store results carry no data word
            wb_data <= make_wb(held, (held.op == op_load) ? rsp.rdata : '0);
        end
    end

endmodule

// ==== verilog/bank_router.sv ====
`timescale 1ns/1ps
`include "mem_stage_defines.svh"

module bank_router
    import mem_pkg::*;
(
    // Request from the memory stage
    input  logic                      req_valid,
    input  bank_req_t                 req,

    // Bank strobes, one per bank
    output logic [`MEM_NUM_BANKS-1:0] bank_valid,

    // Broadcast to every bank
    output logic [`MEM_ROW_W-1:0]     row,
    output logic [`MEM_DATA_W-1:0]    wdata,
    output logic                      write
);

    // Bank index sits just above the byte offset, row just above that
    localparam int BANK_LSB = `MEM_BYTE_OFS_W;
    localparam int ROW_LSB  = `MEM_BYTE_OFS_W + `MEM_BANK_SEL_W;

    logic [`MEM_BANK_SEL_W-1:0] bank_sel;  // Word address modulo bank count

    always_comb
    begin
        bank_sel = req.addr[BANK_LSB +: `MEM_BANK_SEL_W];
        row      = req.addr[ROW_LSB +: `MEM_ROW_W];  // Upper bits alias
        wdata    = req.wdata;
        write    = req.write;

        // One-hot strobe toward the selected bank
        for (int i = 0; i < `MEM_NUM_BANKS; i++)
        begin
            bank_valid[i] = req_valid && (bank_sel == i[`MEM_BANK_SEL_W-1:0]);
        end
    end

endmodule

// ==== verilog/data_bank.sv ====
`timescale 1ns/1ps
`include "mem_stage_defines.svh"

module data_bank
    import mem_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,

    // Strobe and shared request fields from the router
    input  logic                   bank_valid,
    input  logic [`MEM_ROW_W-1:0]  row,
    input  logic [`MEM_DATA_W-1:0] wdata,
    input  logic                   write,

    // Registered response
    output logic                   rsp_valid,
    output bank_rsp_t              rsp
);

    // Word storage
    logic [`MEM_DATA_W-1:0] mem [`MEM_BANK_DEPTH];

    // Response strobe follows the request by one cycle
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            rsp_valid <= 1'b0;
        end
        else
        begin
            rsp_valid <= bank_valid;
        end
    end

    // Array access
    always_ff @(posedge clk)
    begin
        if (bank_valid)
        begin
            if (write)
            begin
                mem[row]  <= wdata;
                rsp.rdata <= wdata;  // Store echoes the written word
            end
            else
            begin
                rsp.rdata <= mem[row];  // Read before any later write
            end
        end
    end

endmodule

// ==== verilog/response_merge.sv ====
`timescale 1ns/1ps
`include "mem_stage_defines.svh"

module response_merge
    import mem_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,

    // Per-bank responses
    input  logic [`MEM_NUM_BANKS-1:0] rsp_valid,
    input  bank_rsp_t                 rsp [`MEM_NUM_BANKS],

    // Merged response to the memory stage
    output logic                      done,
    output bank_rsp_t                 rsp_out
);

    logic      any_valid;  // Some bank answered this cycle
    bank_rsp_t merged;     // Data of the answering bank

    // AND-OR select; at most one bank strobes at a time
    always_comb
    begin
        any_valid    = |rsp_valid;
        merged.rdata = '0;
        for (int i = 0; i < `MEM_NUM_BANKS; i++)
        begin
            merged.rdata = merged.rdata | ({`MEM_DATA_W{rsp_valid[i]}} & rsp[i].rdata);
        end
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            done <= 1'b0;
        end
        else
        begin
            done <= any_valid;  // One-cycle strobe
        end
    end

    always_ff @(posedge clk)
    begin
        if (any_valid)
        begin
            rsp_out <= merged;
        end
    end

endmodule

// ==== verilog/mem_subsystem_top.sv ====
`timescale 1ns/1ps
`include "mem_stage_defines.svh"

module mem_subsystem_top
    import mem_pkg::*;
(
    input  logic    clk,
    input  logic    rst,

    // Execute stage side
    input  logic    ex_valid,
    input  ex_mem_t ex_data,
    output logic    stall,

    // Write-back side
    output logic    wb_valid,
    output mem_wb_t wb_data
);

    // Stage to router
    logic      req_valid;
    bank_req_t req;

    // Router to bank array
    logic [`MEM_NUM_BANKS-1:0] bank_valid;
    logic [`MEM_ROW_W-1:0]     row;
    logic [`MEM_DATA_W-1:0]    wdata;
    logic                      write;

    // Bank array to merge
    logic [`MEM_NUM_BANKS-1:0] bank_rsp_valid;
    bank_rsp_t                 bank_rsp [`MEM_NUM_BANKS];

    // Merge back to stage
    logic      done;
    bank_rsp_t rsp;

    mem_stage u_mem_stage (
        .clk       (clk),
        .rst       (rst),
        .ex_valid  (ex_valid),
        .ex_data   (ex_data),
        .done      (done),
        .rsp       (rsp),
        .stall     (stall),
        .req_valid (req_valid),
        .req       (req),
        .wb_valid  (wb_valid),
        .wb_data   (wb_data)
    );

    bank_router u_bank_router (
        .req_valid  (req_valid),
        .req        (req),
        .bank_valid (bank_valid),
        .row        (row),
        .wdata      (wdata),
        .write      (write)
    );

    // Identical banks, interleaved by word address
    for (genvar i = 0; i < `MEM_NUM_BANKS; i++)
    begin : g_bank
        data_bank u_data_bank (
            .clk        (clk),
            .rst        (rst),
            .bank_valid (bank_valid[i]),
            .row        (row),
            .wdata      (wdata),
            .write      (write),
            .rsp_valid  (bank_rsp_valid[i]),
            .rsp        (bank_rsp[i])
        );
    end

    response_merge u_response_merge (
        .clk       (clk),
        .rst       (rst),
        .rsp_valid (bank_rsp_valid),
        .rsp       (bank_rsp),
        .done      (done),
        .rsp_out   (rsp)
    );

endmodule

// ==== verification/mem_subsystem_checker.sv ====
`timescale 1ns/1ps

module mem_subsystem_checker
    import mem_pkg::*;
(
    input logic    clk,
    input logic    rst,
    input logic    ex_valid,
    input ex_mem_t ex_data,
    input logic    stall,
    input logic    req_valid,  // Internal stage request strobe
    input logic    done,       // Internal merge completion strobe
    input logic    wb_valid,
    input mem_wb_t wb_data
);

    logic accept;  // Record taken on this edge
    assign accept = ex_valid && !stall;

    // Upstream holds off while stalled
    a_no_ex_in_stall: assert property (@(posedge clk) disable iff (rst)
        !(ex_valid && stall))
        else $error("ex_valid was high while stall was high");

    // Pass-through record leaves one cycle later with no data word
    a_none_latency: assert property (@(posedge clk) disable iff (rst)
        accept && ex_data.op == op_none |=> wb_valid && !stall && wb_data.load_data == '0)
        else $error("op none record did not produce a clean write-back next cycle");

    // Memory access starts with a request and a stall
    a_mem_start: assert property (@(posedge clk) disable iff (rst)
        accept && ex_data.op != op_none |=> stall && req_valid && !wb_valid)
        else $error("load or store did not raise stall and req_valid");

    a_req_pulse: assert property (@(posedge clk) disable iff (rst)
        req_valid |=> !req_valid)
        else $error("req_valid stayed high for more than one cycle");

    // Stall lasts exactly three cycles
    a_stall_len: assert property (@(posedge clk) disable iff (rst)
        $fell(stall) |-> $past(stall, 2) && $past(stall, 3) && !$past(stall, 4))
        else $error("stall was not high for exactly three cycles");

    // Write-back rises as stall falls, never two memory strobes in a row
    a_wb_on_release: assert property (@(posedge clk) disable iff (rst)
        $fell(stall) |-> wb_valid && !$past(wb_valid))
        else $error("write-back strobe did not line up with the end of stall");

    // Quiet outputs right after reset
    a_reset_state: assert property (@(posedge clk)
        $fell(rst) |-> !stall && !wb_valid && !req_valid && !done)
        else $error("strobes or stall not low after reset");

endmodule

bind mem_subsystem_top mem_subsystem_checker u_checker (
    .clk       (clk),
    .rst       (rst),
    .ex_valid  (ex_valid),
    .ex_data   (ex_data),
    .stall     (stall),
    .req_valid (req_valid),
    .done      (done),
    .wb_valid  (wb_valid),
    .wb_data   (wb_data)
);

// ==== verification/mem_subsystem_tb.sv ====
`timescale 1ns/1ps
`include "mem_stage_defines.svh"

module mem_subsystem_tb
    import mem_pkg::*;
();

    localparam int WINDOW      = 32;    // Words exercised, spans every bank
    localparam int NUM_RANDOM  = 136;
    localparam int MAX_CYCLES  = 5000;  // About 200 records at five cycles each, wide margin
    localparam int HI_LSB      = `MEM_BYTE_OFS_W + `MEM_BANK_SEL_W + `MEM_ROW_W;
    localparam int MODEL_WORDS = `MEM_NUM_BANKS * `MEM_BANK_DEPTH;
    localparam int IDX_W       = $clog2(MODEL_WORDS);

    logic    clk = 1'b0;
    logic    rst;
    logic    ex_valid;
    ex_mem_t ex_data;
    logic    stall;
    logic    wb_valid;
    mem_wb_t wb_data;

    logic [`MEM_DATA_W-1:0] model_mem [MODEL_WORDS];  // Reference memory
    mem_wb_t expected_q [$];
    mem_wb_t exp_rec;
    int      cycle_count = 0;

    mem_subsystem_top DUT (
        .clk      (clk),
        .rst      (rst),
        .ex_valid (ex_valid),
        .ex_data  (ex_data),
        .stall    (stall),
        .wb_valid (wb_valid),
        .wb_data  (wb_data)
    );

    always #4 clk = ~clk;  // 8 ns period

    // Byte address for a window word, random alias and offset bits
    function automatic logic [`MEM_ADDR_W-1:0] make_addr(input int word);
        logic [`MEM_ADDR_W-1:0] hi;
        logic [`MEM_ADDR_W-1:0] lo;
        logic [`MEM_ADDR_W-1:0] w;
        hi = ($urandom() % 3 == 0) ? '0 : $urandom();
        lo = $urandom() % 4;
        w  = word;
        return (hi << HI_LSB) | (w << `MEM_BYTE_OFS_W) | lo;
    endfunction

    // Bank and row per the interleaving rule, flattened
    function automatic logic [IDX_W-1:0] model_index(input logic [`MEM_ADDR_W-1:0] addr);
        logic [`MEM_ADDR_W-1:0] word_addr;
        logic [`MEM_ADDR_W-1:0] bank;
        logic [`MEM_ADDR_W-1:0] row;
        logic [`MEM_ADDR_W-1:0] flat;
        word_addr = addr >> `MEM_BYTE_OFS_W;
        bank      = word_addr % `MEM_NUM_BANKS;
        row       = (word_addr / `MEM_NUM_BANKS) % `MEM_BANK_DEPTH;  // High bits alias
        flat      = row * `MEM_NUM_BANKS + bank;
        return flat[IDX_W-1:0];
    endfunction

    function automatic mem_op_t random_op();
        mem_op_t op;
        int      pick;
        pick = $urandom_range(2, 0);
        op   = (pick == 0) ? op_none : (pick == 1) ? op_load : op_store;
        return op;
    endfunction

    function automatic ex_mem_t make_record(input int word, input mem_op_t op);
        ex_mem_t     r;
        logic [31:0] rnd;
        rnd             = $urandom();
        r.alu_result    = make_addr(word);
        r.store_data    = $urandom();
        r.op            = op;
        r.mem_to_reg    = rnd[0];
        r.reg_write     = rnd[1];
        r.reg_dest      = rnd[2 +: `MEM_REG_W];
        r.pc_src        = rnd[7];
        r.branch_target = $urandom();
        return r;
    endfunction

    task automatic stop_run();
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic report_mismatch(input string field);
        $display("FAIL at %0t ns: wb_data.%s differs from the expected value", $time, field);
        stop_run();
    endtask

    // Waits out stall, predicts the result, then strobes one record
    task automatic send_record(input ex_mem_t rec);
        mem_wb_t          want;
        logic [IDX_W-1:0] idx;
        while (stall)
        begin
            @(posedge clk);
            #1;
        end
        idx                = model_index(rec.alu_result);
        want.load_data     = (rec.op == op_load) ? model_mem[idx] : '0;
        want.alu_result    = rec.alu_result;
        want.mem_to_reg    = rec.mem_to_reg;
        want.reg_write     = rec.reg_write;
        want.reg_dest      = rec.reg_dest;
        want.pc_src        = rec.pc_src;
        want.branch_target = rec.branch_target;
        if (rec.op == op_store)
        begin
            model_mem[idx] = rec.store_data;  // Issue order equals write order
        end
        expected_q.push_back(want);
        ex_valid = 1'b1;
        ex_data  = rec;
        @(posedge clk);
        #1;
        ex_valid = 1'b0;
    endtask

    // Outputs are stable mid-cycle
    always @(negedge clk)
    begin
        if (!rst && wb_valid)
        begin
            if (expected_q.size() == 0)
            begin
                $display("Write-back strobe arrived with no record outstanding");
                stop_run();
            end
            else
            begin
                exp_rec = expected_q.pop_front();
                assert (wb_data.load_data == exp_rec.load_data)
                    else report_mismatch("load_data");
                assert (wb_data.alu_result == exp_rec.alu_result)
                    else report_mismatch("alu_result");
                assert (wb_data.mem_to_reg == exp_rec.mem_to_reg)
                    else report_mismatch("mem_to_reg");
                assert (wb_data.reg_write == exp_rec.reg_write)
                    else report_mismatch("reg_write");
                assert (wb_data.reg_dest == exp_rec.reg_dest)
                    else report_mismatch("reg_dest");
                assert (wb_data.pc_src == exp_rec.pc_src)
                    else report_mismatch("pc_src");
                assert (wb_data.branch_target == exp_rec.branch_target)
                    else report_mismatch("branch_target");
            end
        end
    end

    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count > MAX_CYCLES)
        begin
            $display("Timeout after %0d cycles, %0d records still outstanding",
                     MAX_CYCLES, expected_q.size());
            stop_run();
        end
    end

    initial
    begin
        void'($urandom(32'hfbed));
        rst      = 1'b1;
        ex_valid = 1'b0;
        ex_data  = '0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        // Fill every window word so no load sees an unwritten word
        for (int w = 0; w < WINDOW; w++)
        begin
            send_record(make_record(w, op_store));
        end

        // Directed mapping and alias checks
        for (int w = 0; w < 8; w++)
        begin
            send_record(make_record(w, op_store));
            send_record(make_record(w, op_load));                   // New alias bits
            send_record(make_record(w + `MEM_NUM_BANKS, op_load));  // Same bank, next row
            send_record(make_record(w + 1, op_load));               // Neighbour bank
        end

        for (int n = 0; n < NUM_RANDOM; n++)
        begin
            send_record(make_record(int'($urandom_range(WINDOW - 1, 0)), random_op()));
            if ($urandom_range(3, 0) == 0)
            begin
                @(posedge clk);  // Occasional idle cycle
                #1;
            end
        end

        while (expected_q.size() != 0)
        begin
            @(posedge clk);
        end
        // A few quiet cycles so a stray strobe still hits the monitor
        repeat (3) @(posedge clk);
        #1;
        $display("TESTS PASSED");
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+common
common/mem_pkg.sv
mem_stage/mem_stage.sv
verilog/bank_router.sv
verilog/data_bank.sv
verilog/response_merge.sv
verilog/mem_subsystem_top.sv
verification/mem_subsystem_checker.sv
verification/mem_subsystem_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator and run it, exit status follows the result

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 \
    --timescale 1ns/1ps \
    -f verilog.f \
    --top-module mem_subsystem_tb \
    -o mem_subsystem_sim &&
./obj_dir/mem_subsystem_sim +verilator+error+limit+1 ||
{
    echo "Simulation build or run failed"
    exit 1
}
